// ==== filelist.f ====
logic/csr_pkg.sv
logic/csr_access.sv
logic/csr_trap_unit.sv
logic/csr_counters.sv
logic/csr_file.sv
dv/csr_file_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the csr file testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module csr_file_tb -f filelist.f -o csr_file_sim

output=$(./obj_dir/csr_file_sim)
echo "$output"

if echo "$output" | grep -qx "TEST PASSED"; then
   exit 0
else
   exit 1
fi

// ==== dv/csr_file_tb.sv ====
`timescale 1ns/1ps

module csr_file_tb;

   localparam int             N_EXT_INTS      = 4;
   localparam csr_pkg::xlen_t MTVEC_RESET     = 32'h8000_0000;
   localparam int             RANDOM_OPS      = 24;
   localparam int             RETIRE_SLOTS    = 20;
   localparam int             WATCHDOG_CYCLES = 2000;         // tests need about 150 cycles
   localparam csr_pkg::xlen_t EXP_MISA        = 32'h4010_0100;  // mxl 1, extensions i and u

   logic clk, reset, retire, illegal_access, interrupt_pending, interrupt_taken;
   csr_pkg::csr_addr_t    addr;
   csr_pkg::csr_cmd_t     cmd;
   csr_pkg::xlen_t        wdata, rdata, handler_pc, epc;
   csr_pkg::prv_t         prv;
   csr_pkg::trap_event_t  trap;
   logic [N_EXT_INTS-1:0] ext_interrupts;

   csr_pkg::xlen_t    last_rdata, m_mscratch, m_mtvec;  // model state
   csr_pkg::xlen_t    r, x, old, nv, pc;
   logic [7:0]        m_stack;                          // model of the privilege stack
   logic              last_illegal;
   csr_pkg::csr_cmd_t c;
   csr_pkg::csr_addr_t a;
   logic [31:0]       seed;
   int                errors, checks, i, n, line, retired;

   csr_file #(.N_EXT_INTS(N_EXT_INTS), .MTVEC_RESET(MTVEC_RESET)) uut (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
      checks++;
      assert (got === exp)
      else begin
         errors++;
         $display("MISMATCH %s: expected %h, got %h", name, exp, got);
      end
   endtask

   // one command on the port with outputs sampled after the drive settles
   task automatic csr_cycle(input csr_pkg::csr_cmd_t cc, input csr_pkg::csr_addr_t aa,
                            input csr_pkg::xlen_t dd);
      @(negedge clk);
      cmd   = cc;
      addr  = aa;
      wdata = dd;
      #1;
      last_rdata   = rdata;
      last_illegal = illegal_access;
   endtask

   task automatic read_expect(input string name, input csr_pkg::csr_addr_t aa,
                              input csr_pkg::xlen_t exp);
      csr_cycle(csr_pkg::CMD_READ, aa, '0);
      check_value(name, exp, last_rdata);
      check_value({name, " illegal"}, 32'd0, {31'b0, last_illegal});
   endtask

   task automatic idle_cycles(input int count);
      repeat (count) begin
         @(negedge clk);
         cmd = csr_pkg::CMD_IDLE;
      end
   endtask

   // one cycle of exception or eret with the model stack following
   task automatic pulse_trap(input logic exc, input csr_pkg::cause_t cause,
                             input csr_pkg::xlen_t tpc, input csr_pkg::xlen_t fault,
                             input logic eret);
      @(negedge clk);
      cmd            = csr_pkg::CMD_IDLE;
      trap.exception = exc;
      trap.cause     = cause;
      trap.pc        = tpc;
      trap.addr      = fault;
      trap.eret      = eret;
      @(negedge clk);
      trap = '0;
      if (exc)
         m_stack = {m_stack[3:0], 4'h0};  // push
      else if (eret)
         m_stack = {4'h0, m_stack[7:4]};  // pop
   endtask

   initial begin
      seed = 32'hcad4;
      errors = 0;
      checks = 0;
      reset = 1'b1;
      retire = 1'b0;
      addr = '0;
      cmd = csr_pkg::CMD_IDLE;
      wdata = '0;
      trap = '0;
      ext_interrupts = '0;
      m_stack = 8'h00;
      m_mtvec = MTVEC_RESET;
      repeat (8) @(posedge clk);
      @(negedge clk) reset = 1'b0;

      // ==================================================
      // reset values
      // ==================================================
      #1;
      check_value("reset prv", {30'b0, csr_pkg::PRV_M}, {30'b0, prv});
      check_value("reset interrupt_taken", 32'd0, {31'b0, interrupt_taken});
      read_expect("reset mstatus", csr_pkg::ADDR_MSTATUS, 32'd0);
      read_expect("reset mie", csr_pkg::ADDR_MIE, 32'd0);
      read_expect("reset mtvec", csr_pkg::ADDR_MTVEC, MTVEC_RESET);
      read_expect("misa", csr_pkg::ADDR_MISA, EXP_MISA);
      read_expect("mhartid", csr_pkg::ADDR_MHARTID, 32'd0);

      // ==================================================
      // random write / set / clear on mscratch and mtvec
      // ==================================================
      m_mscratch = lcg_next();  // mscratch has no reset value
      csr_cycle(csr_pkg::CMD_WRITE, csr_pkg::ADDR_MSCRATCH, m_mscratch);
      for (i = 0; i < RANDOM_OPS; i++) begin
         r   = lcg_next();
         x   = lcg_next();
         a   = r[0] ? csr_pkg::ADDR_MSCRATCH : csr_pkg::ADDR_MTVEC;
         old = r[0] ? m_mscratch : m_mtvec;
         case ((r >> 4) % 32'd3)
            32'd0: begin
               c  = csr_pkg::CMD_WRITE;
               nv = x;
            end
            32'd1: begin
               c  = csr_pkg::CMD_SET;
               nv = old | x;
            end
            default: begin
               c  = csr_pkg::CMD_CLEAR;
               nv = old & ~x;
            end
         endcase
         csr_cycle(c, a, x);
         check_value("random op old value", old, last_rdata);  // rdata shows the old value
         check_value("random op illegal", 32'd0, {31'b0, last_illegal});
         if (r[0])
            m_mscratch = nv;
         else
            m_mtvec = {nv[31:2], 2'b00};  // low bits always clear
      end
      read_expect("final mscratch", csr_pkg::ADDR_MSCRATCH, m_mscratch);
      read_expect("final mtvec", csr_pkg::ADDR_MTVEC, m_mtvec);

      // ==================================================
      // illegal accesses
      // ==================================================
      csr_cycle(csr_pkg::CMD_WRITE, csr_pkg::ADDR_MVENDORID, lcg_next());
      check_value("mvendorid write illegal", 32'd1, {31'b0, last_illegal});
      read_expect("mvendorid unchanged", csr_pkg::ADDR_MVENDORID, 32'd0);
      csr_cycle(csr_pkg::CMD_READ, 12'h3A0, '0);  // pmpcfg0 is not implemented
      check_value("undefined read illegal", 32'd1, {31'b0, last_illegal});
      m_stack = 8'hA5;  // both nibbles set so pop and push stay visible
      csr_cycle(csr_pkg::CMD_WRITE, csr_pkg::ADDR_MSTATUS, {24'b0, m_stack});
      pulse_trap(1'b0, '0, '0, '0, 1'b1);  // mret drops to user
      check_value("mret prv", {30'b0, csr_pkg::PRV_U}, {30'b0, prv});
      csr_cycle(csr_pkg::CMD_WRITE, csr_pkg::ADDR_MSCRATCH, ~m_mscratch);
      check_value("user mscratch illegal", 32'd1, {31'b0, last_illegal});
      csr_cycle(csr_pkg::CMD_READ, csr_pkg::ADDR_CYCLE, '0);
      check_value("user cycle read illegal", 32'd0, {31'b0, last_illegal});

      // ==================================================
      // exceptions and eret
      // ==================================================
      pc = lcg_next();
      x  = lcg_next();
      pulse_trap(1'b1, csr_pkg::CAUSE_ILLEGAL_INST, pc, x, 1'b0);
      check_value("exception epc", {pc[31:2], 2'b00}, epc);
      check_value("exception prv", {30'b0, csr_pkg::PRV_M}, {30'b0, prv});
      check_value("exception handler_pc", m_mtvec, handler_pc);
      read_expect("exception mcause", csr_pkg::ADDR_MCAUSE, {28'b0, csr_pkg::CAUSE_ILLEGAL_INST});
      read_expect("exception mtval", csr_pkg::ADDR_MTVAL, x);         // faulting address
      read_expect("exception mstatus", csr_pkg::ADDR_MSTATUS, {24'b0, m_stack});
      read_expect("mscratch after illegal write", csr_pkg::ADDR_MSCRATCH, m_mscratch);
      pc = lcg_next() | 32'd2;
      pulse_trap(1'b1, csr_pkg::CAUSE_INST_MISALIGNED, pc, lcg_next(), 1'b0);
      read_expect("misaligned mtval", csr_pkg::ADDR_MTVAL, pc);       // the pc, unaligned
      read_expect("misaligned mcause", csr_pkg::ADDR_MCAUSE, 32'd0);
      m_stack = 8'(lcg_next());
      csr_cycle(csr_pkg::CMD_WRITE, csr_pkg::ADDR_MSTATUS, {24'b0, m_stack});
      pulse_trap(1'b0, '0, '0, '0, 1'b1);
      check_value("eret prv", {30'b0, csr_pkg::PRV_U}, {30'b0, prv});
      pulse_trap(1'b1, csr_pkg::CAUSE_ECALL_U, lcg_next(), '0, 1'b0);
      read_expect("stack after pop and push", csr_pkg::ADDR_MSTATUS, {24'b0, m_stack});

      // ==================================================
      // external interrupt
      // ==================================================
      line    = int'(lcg_next() % N_EXT_INTS);
      m_stack = 8'h08;  // machine interrupt enable
      csr_cycle(csr_pkg::CMD_WRITE, csr_pkg::ADDR_MSTATUS, {24'b0, m_stack});
      csr_cycle(csr_pkg::CMD_WRITE, csr_pkg::ADDR_MIE, 32'd1 << (8 + line));
      pc = lcg_next();
      @(negedge clk);
      cmd                  = csr_pkg::CMD_IDLE;
      ext_interrupts[line] = 1'b1;
      trap.pc              = pc;
      #1;
      check_value("interrupt_pending", 32'd1, {31'b0, interrupt_pending});
      check_value("interrupt_taken", 32'd1, {31'b0, interrupt_taken});
      @(negedge clk);
      trap    = '0;
      m_stack = {m_stack[3:0], 4'h0};
      check_value("interrupt epc", {pc[31:2], 2'b00} + 32'd4, epc);
      read_expect("interrupt mcause", csr_pkg::ADDR_MCAUSE, 32'h8000_0007);
      read_expect("interrupt mip", csr_pkg::ADDR_MIP, 32'd1 << (8 + line));
      read_expect("interrupt mstatus", csr_pkg::ADDR_MSTATUS, {24'b0, m_stack});
      check_value("interrupt masked after push", 32'd0, {31'b0, interrupt_taken});
      @(negedge clk) ext_interrupts = '0;

      // ==================================================
      // counters
      // ==================================================
      x = lcg_next() & 32'h7FFF_FFFF;  // keep clear of a low half carry
      n = 1 + int'(lcg_next() % 32'd8);
      csr_cycle(csr_pkg::CMD_WRITE, csr_pkg::ADDR_MCYCLE, x);
      idle_cycles(n);
      read_expect("mcycle after write", csr_pkg::ADDR_MCYCLE, x + 32'(n));
      nv = lcg_next();
      csr_cycle(csr_pkg::CMD_WRITE, csr_pkg::ADDR_MCYCLEH, nv);
      read_expect("cycleh written", csr_pkg::ADDR_CYCLEH, nv);
      // two more edges, the low half is held on the write edge
      read_expect("cycle low kept", csr_pkg::ADDR_CYCLE, x + 32'(n) + 32'd2);
      read_expect("instret start", csr_pkg::ADDR_MINSTRET, 32'd0);
      retired = 0;
      for (i = 0; i < RETIRE_SLOTS; i++) begin
         r = lcg_next();
         @(negedge clk);
         cmd    = csr_pkg::CMD_IDLE;
         retire = r[7];
         if (r[7])
            retired++;
      end
      @(negedge clk) retire = 1'b0;
      read_expect("instret count", csr_pkg::ADDR_MINSTRET, 32'(retired));
      read_expect("instreth", csr_pkg::ADDR_INSTRETH, 32'd0);

      idle_cycles(1);
      $display("run complete: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== logic/csr_file.sv ====
`timescale 1ns/1ps

module csr_file #(
   parameter int             N_EXT_INTS  = 4,             // at most 24
   parameter csr_pkg::xlen_t MTVEC_RESET = 32'h8000_0000
) (
   input  logic                  clk,
   input  logic                  reset,
   // core side command port, one access per cycle
   input  csr_pkg::csr_addr_t    addr,
   input  csr_pkg::csr_cmd_t     cmd,
   input  csr_pkg::xlen_t        wdata,
   output csr_pkg::xlen_t        rdata,
   output logic                  illegal_access,
   output csr_pkg::prv_t         prv,
   // interrupts and traps
   input  logic [N_EXT_INTS-1:0] ext_interrupts,
   input  csr_pkg::trap_event_t  trap,
   input  logic                  retire,
   output csr_pkg::xlen_t        handler_pc,
   output csr_pkg::xlen_t        epc,
   output logic                  interrupt_pending,
   output logic                  interrupt_taken
);

   csr_pkg::csr_write_t wr;       // shared write bus
   csr_pkg::csr_read_t  trap_rd;
   csr_pkg::csr_read_t  cnt_rd;

   csr_access u_access (
      .addr           (addr),
      .cmd            (cmd),
      .wdata          (wdata),
      .trap_rd        (trap_rd),
      .cnt_rd         (cnt_rd),
      .prv            (prv),
      .wr             (wr),
      .rdata          (rdata),
      .illegal_access (illegal_access)
   );

   csr_trap_unit #(
      .N_EXT_INTS  (N_EXT_INTS),
      .MTVEC_RESET (MTVEC_RESET)
   ) u_trap (
      .clk               (clk),
      .reset             (reset),
      .wr                (wr),
      .addr              (addr),
      .rd                (trap_rd),
      .ext_interrupts    (ext_interrupts),
      .trap              (trap),
      .prv               (prv),
      .handler_pc        (handler_pc),
      .epc               (epc),
      .interrupt_pending (interrupt_pending),
      .interrupt_taken   (interrupt_taken)
   );

   csr_counters u_counters (
      .clk    (clk),
      .reset  (reset),
      .wr     (wr),
      .addr   (addr),
      .rd     (cnt_rd),
      .retire (retire)
   );

endmodule

// ==== logic/csr_counters.sv ====
`timescale 1ns/1ps

module csr_counters (
   input  logic                clk,
   input  logic                reset,
   input  csr_pkg::csr_write_t wr,
   input  csr_pkg::csr_addr_t  addr,
   output csr_pkg::csr_read_t  rd,
   input  logic                retire   // one pulse per completed instruction
);

   csr_pkg::counter_t cycle_q;
   csr_pkg::counter_t instret_q;

   logic cyc_lo, cyc_hi;   // write strobes per half
   logic ret_lo, ret_hi;

   // next value of one counter, a write beats the increment
   function automatic csr_pkg::counter_t step(input csr_pkg::counter_t cur,
                                              input logic inc,
                                              input logic wr_lo,
                                              input logic wr_hi,
                                              input csr_pkg::xlen_t d);
      csr_pkg::counter_t nxt;
      nxt = cur;
      if (wr_lo)
         nxt[31:0] = d;
      else if (wr_hi)
         nxt[63:32] = d;   // low half holds
      else if (inc)
         nxt = cur + 64'd1;
      return nxt;
   endfunction

   // user shadows also decode, the access check keeps them read-only
   assign cyc_lo = wr.en && (wr.addr == csr_pkg::ADDR_MCYCLE || wr.addr == csr_pkg::ADDR_CYCLE);
   assign cyc_hi = wr.en && (wr.addr == csr_pkg::ADDR_MCYCLEH || wr.addr == csr_pkg::ADDR_CYCLEH);
   assign ret_lo = wr.en && (wr.addr == csr_pkg::ADDR_MINSTRET ||
                             wr.addr == csr_pkg::ADDR_INSTRET);
   assign ret_hi = wr.en && (wr.addr == csr_pkg::ADDR_MINSTRETH ||
                             wr.addr == csr_pkg::ADDR_INSTRETH);

   always_ff @(posedge clk) begin
      if (reset) begin
         cycle_q   <= '0;
         instret_q <= '0;
      end else begin
         cycle_q   <= step(cycle_q, 1'b1, cyc_lo, cyc_hi, wr.data);    // free running
         instret_q <= step(instret_q, retire, ret_lo, ret_hi, wr.data);
      end
   end

   always_comb begin
      rd.hit  = 1'b1;
      rd.data = '0;
      case (addr)
         csr_pkg::ADDR_CYCLE,    csr_pkg::ADDR_MCYCLE:    rd.data = cycle_q[31:0];
         csr_pkg::ADDR_CYCLEH,   csr_pkg::ADDR_MCYCLEH:   rd.data = cycle_q[63:32];
         csr_pkg::ADDR_INSTRET,  csr_pkg::ADDR_MINSTRET:  rd.data = instret_q[31:0];
         csr_pkg::ADDR_INSTRETH, csr_pkg::ADDR_MINSTRETH: rd.data = instret_q[63:32];
         default:                                         rd.hit  = 1'b0;
      endcase
   end

endmodule

// ==== logic/csr_trap_unit.sv ====
`timescale 1ns/1ps

module csr_trap_unit #(
   parameter int             N_EXT_INTS  = 4,
   parameter csr_pkg::xlen_t MTVEC_RESET = 32'h8000_0000
) (
   input  logic                   clk,
   input  logic                   reset,
   input  csr_pkg::csr_write_t    wr,              // from csr_access
   input  csr_pkg::csr_addr_t     addr,            // read address of the port
   output csr_pkg::csr_read_t     rd,
   input  logic [N_EXT_INTS-1:0]  ext_interrupts,
   input  csr_pkg::trap_event_t   trap,
   output csr_pkg::prv_t          prv,
   output csr_pkg::xlen_t         handler_pc,
   output csr_pkg::xlen_t         epc,
   output logic                   interrupt_pending,
   output logic                   interrupt_taken
);

   csr_pkg::prv_t   mode;        // current privilege
   logic [7:0]      priv_stack;  // mstatus low byte, pushed / popped by nibble
   csr_pkg::xlen_t  mtvec;
   csr_pkg::xlen_t  mie;
   logic            mtip;        // software visible pending bits
   logic            msip;
   csr_pkg::xlen_t  mscratch;
   csr_pkg::xlen_t  mepc;
   logic            mint;        // mcause interrupt bit
   csr_pkg::cause_t mecode;
   csr_pkg::xlen_t  mtval;

   csr_pkg::xlen_t  mstatus;
   csr_pkg::xlen_t  mip;
   csr_pkg::xlen_t  mcause;
   csr_pkg::xlen_t  pc_aligned;
   logic            any_enabled;

   // write strobe for one register
   function automatic logic wr_to(input csr_pkg::csr_addr_t a);
      return wr.en && (wr.addr == a);
   endfunction

   // ==================================================
   // interrupt decision
   // ==================================================
   always_comb begin
      mip = '0;
      mip[3] = msip;
      mip[7] = mtip;
      mip[8 +: N_EXT_INTS] = ext_interrupts;  // external lines from bit 8 up
   end

   assign any_enabled       = |(mie & mip);
   assign interrupt_pending = |mip;  // masked or not
   // user mode always takes, machine mode needs mie in the stack
   assign interrupt_taken   = (mode == csr_pkg::PRV_U) ? any_enabled
                                                      : (any_enabled && priv_stack[3]);

   assign pc_aligned = {trap.pc[31:2], 2'b00};
   assign mstatus    = {24'b0, priv_stack};
   assign mcause     = {mint, 27'b0, mecode};
   assign prv        = mode;
   assign handler_pc = mtvec;  // single vector for all traps
   assign epc        = mepc;

   // ==================================================
   // privilege and stack
   // ==================================================
   always_ff @(posedge clk) begin
      if (reset) begin
         mode       <= csr_pkg::PRV_M;  // start in machine mode
         priv_stack <= 8'h00;           // interrupts off
      end else begin
         if (interrupt_taken || trap.exception)
            mode <= csr_pkg::PRV_M;
         else if (trap.eret)
            mode <= csr_pkg::PRV_U;     // mret only goes back to user

         if (wr_to(csr_pkg::ADDR_MSTATUS))
            priv_stack <= wr.data[7:0];
         else if (interrupt_taken || trap.exception)
            priv_stack <= {priv_stack[3:0], 4'h0};  // push
         else if (trap.eret)
            priv_stack <= {4'h0, priv_stack[7:4]};  // pop
      end
   end

   // ==================================================
   // trap registers
   // ==================================================
   always_ff @(posedge clk) begin
      if (reset) begin
         mtvec  <= MTVEC_RESET;
         mie    <= '0;
         mtip   <= 1'b0;
         msip   <= 1'b0;
         mepc   <= '0;
         mint   <= 1'b0;
         mecode <= '0;
         mtval  <= '0;
      end else begin
         if (wr_to(csr_pkg::ADDR_MTVEC))
            mtvec <= {wr.data[31:2], 2'b00};  // direct mode only
         if (wr_to(csr_pkg::ADDR_MIE))
            mie <= wr.data;
         if (wr_to(csr_pkg::ADDR_MIP)) begin
            mtip <= wr.data[7];
            msip <= wr.data[3];
         end

         if (wr_to(csr_pkg::ADDR_MEPC))
            mepc <= {wr.data[31:2], 2'b00};
         else if (interrupt_taken)
            mepc <= pc_aligned + 32'd4;  // resume after the interrupted one
         else if (trap.exception)
            mepc <= pc_aligned;          // retry the faulting one

         if (wr_to(csr_pkg::ADDR_MCAUSE)) begin
            mint   <= wr.data[31];
            mecode <= wr.data[3:0];
         end else if (interrupt_taken) begin
            mint   <= 1'b1;
            mecode <= csr_pkg::ICODE_TIMER;
         end else if (trap.exception) begin
            mint   <= 1'b0;
            mecode <= trap.cause;
         end

         // an interrupt in the same cycle leaves mtval alone
         if (wr_to(csr_pkg::ADDR_MTVAL))
            mtval <= wr.data;
         else if (trap.exception && !interrupt_taken)
            mtval <= (trap.cause == csr_pkg::CAUSE_INST_MISALIGNED) ? trap.pc : trap.addr;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_to(csr_pkg::ADDR_MSCRATCH))
         mscratch <= wr.data;  // handler scratch word
   end

   // ==================================================
   // read decode
   // ==================================================
   always_comb begin
      rd.hit  = 1'b1;
      rd.data = '0;
      case (addr)
         csr_pkg::ADDR_MSTATUS:   rd.data = mstatus;
         csr_pkg::ADDR_MISA:      rd.data = csr_pkg::MISA_VALUE;
         csr_pkg::ADDR_MIE:       rd.data = mie;
         csr_pkg::ADDR_MTVEC:     rd.data = mtvec;
         csr_pkg::ADDR_MSCRATCH:  rd.data = mscratch;
         csr_pkg::ADDR_MEPC:      rd.data = mepc;
         csr_pkg::ADDR_MCAUSE:    rd.data = mcause;
         csr_pkg::ADDR_MTVAL:     rd.data = mtval;
         csr_pkg::ADDR_MIP:       rd.data = mip;
         csr_pkg::ADDR_MVENDORID: rd.data = '0;  // non-commercial
         csr_pkg::ADDR_MARCHID:   rd.data = csr_pkg::MARCHID_VALUE;
         csr_pkg::ADDR_MIMPID:    rd.data = csr_pkg::MIMPID_VALUE;
         csr_pkg::ADDR_MHARTID:   rd.data = '0;  // single hart
         default:                 rd.hit  = 1'b0;
      endcase
   end

endmodule

// ==== logic/csr_access.sv ====
`timescale 1ns/1ps

module csr_access (
   input  csr_pkg::csr_addr_t  addr,
   input  csr_pkg::csr_cmd_t   cmd,
   input  csr_pkg::xlen_t      wdata,
   input  csr_pkg::csr_read_t  trap_rd,   // trap unit decode
   input  csr_pkg::csr_read_t  cnt_rd,    // counter decode
   input  csr_pkg::prv_t       prv,
   output csr_pkg::csr_write_t wr,
   output csr_pkg::xlen_t      rdata,
   output logic                illegal_access
);

   logic access;       // any command but idle
   logic writes;       // write, set or clear
   logic defined;      // some part decoded the address
   logic ro_region;
   logic prv_too_low;
   csr_pkg::xlen_t old_value;

   // ==================================================
   // command decode and legality
   // ==================================================
   assign access  = cmd[2];
   assign writes  = cmd[2] && (cmd[1] || cmd[0]);
   assign defined = trap_rd.hit || cnt_rd.hit;  // at most one part hits

   assign ro_region   = writes && (addr[11:10] == 2'b11);  // 0xC00 and up
   assign prv_too_low = access && (addr[9:8] > prv);       // bits 9:8 give the needed level

   assign illegal_access = ro_region || prv_too_low || (access && !defined);

   // ==================================================
   // read merge
   // ==================================================
   assign old_value = trap_rd.hit ? trap_rd.data : cnt_rd.data;
   assign rdata     = old_value;  // zero on a miss

   // ==================================================
   // write data
   // ==================================================
   always_comb begin
      wr.en   = writes && !illegal_access;  // illegal accesses change nothing
      wr.addr = addr;
      case (cmd)
         csr_pkg::CMD_SET:   wr.data = old_value | wdata;
         csr_pkg::CMD_CLEAR: wr.data = old_value & ~wdata;
         default:            wr.data = wdata;  // plain write
      endcase
   end

endmodule

// ==== logic/csr_pkg.sv ====
package csr_pkg;

   // ==================================================
   // widths and base types
   // ==================================================
   localparam int XLEN       = 32;  // machine word
   localparam int ADDR_WIDTH = 12;  // csr address space

   typedef logic [XLEN-1:0]       xlen_t;      // one machine word
   typedef logic [2*XLEN-1:0]     counter_t;   // cycle / instret
   typedef logic [ADDR_WIDTH-1:0] csr_addr_t;
   typedef logic [2:0]            csr_cmd_t;   // bit 2 = access, bits 1:0 = write kind
   typedef logic [1:0]            prv_t;       // privilege level
   typedef logic [3:0]            cause_t;     // exception code field of mcause

   // ==================================================
   // command, privilege and cause codes
   // ==================================================
   localparam csr_cmd_t CMD_IDLE  = 3'd0;
   localparam csr_cmd_t CMD_READ  = 3'd4;
   localparam csr_cmd_t CMD_WRITE = 3'd5;
   localparam csr_cmd_t CMD_SET   = 3'd6;  // old | wdata
   localparam csr_cmd_t CMD_CLEAR = 3'd7;  // old & ~wdata

   localparam prv_t PRV_U = 2'd0;
   localparam prv_t PRV_M = 2'd3;

   localparam cause_t CAUSE_INST_MISALIGNED = 4'd0;  // mtval gets the pc
   localparam cause_t CAUSE_ILLEGAL_INST    = 4'd2;
   localparam cause_t CAUSE_BREAKPOINT      = 4'd3;  // plain exception here
   localparam cause_t CAUSE_ECALL_U         = 4'd8;
   localparam cause_t ICODE_TIMER           = 4'd7;  // recorded for any interrupt

   // ==================================================
   // csr addresses
   // ==================================================
   // machine trap setup / handling
   localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
   localparam csr_addr_t ADDR_MISA     = 12'h301;
   localparam csr_addr_t ADDR_MIE      = 12'h304;
   localparam csr_addr_t ADDR_MTVEC    = 12'h305;
   localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
   localparam csr_addr_t ADDR_MEPC     = 12'h341;
   localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
   localparam csr_addr_t ADDR_MTVAL    = 12'h343;
   localparam csr_addr_t ADDR_MIP      = 12'h344;

   // identification, read-only region
   localparam csr_addr_t ADDR_MVENDORID = 12'hF11;
   localparam csr_addr_t ADDR_MARCHID   = 12'hF12;
   localparam csr_addr_t ADDR_MIMPID    = 12'hF13;
   localparam csr_addr_t ADDR_MHARTID   = 12'hF14;

   // machine counters, writable
   localparam csr_addr_t ADDR_MCYCLE    = 12'hB00;
   localparam csr_addr_t ADDR_MINSTRET  = 12'hB02;
   localparam csr_addr_t ADDR_MCYCLEH   = 12'hB80;
   localparam csr_addr_t ADDR_MINSTRETH = 12'hB82;

   // user shadows, read-only from the port
   localparam csr_addr_t ADDR_CYCLE     = 12'hC00;
   localparam csr_addr_t ADDR_INSTRET   = 12'hC02;
   localparam csr_addr_t ADDR_CYCLEH    = 12'hC80;
   localparam csr_addr_t ADDR_INSTRETH  = 12'hC82;

   // ==================================================
   // identification words
   // ==================================================
   // mxl = 1 (rv32), extensions i (bit 8) and u (bit 20)
   localparam xlen_t MISA_VALUE    = 32'h4010_0100;
   localparam xlen_t MARCHID_VALUE = 32'h8000_0001;  // msb set, rest nonzero
   localparam xlen_t MIMPID_VALUE  = 32'h0000_8000;  // first version

   // ==================================================
   // shared structs
   // ==================================================
   typedef struct packed {
      logic      en;    // write strobe, legal writes only
      csr_addr_t addr;
      xlen_t     data;  // final value after set / clear
   } csr_write_t;

   typedef struct packed {
      logic  hit;       // address decoded by this part
      xlen_t data;
   } csr_read_t;

   typedef struct packed {
      logic   exception;
      cause_t cause;
      xlen_t  pc;       // pc of the trapping instruction
      xlen_t  addr;     // faulting data address
      logic   eret;     // mret in execute
   } trap_event_t;

endpackage
